//--- include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// CPU side widths
`define DC_ADDR_W      32
`define DC_WORD_W      32

// Cache geometry
`define DC_WAYS        4
`define DC_SETS        16
`define DC_INDEX_W     4
`define DC_LINE_WORDS  16
`define DC_OFFSET_W    4

// Address split is tag [31:10], index [9:6], offset [5:2]
`define DC_TAG_W       22

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

  typedef logic [`DC_WORD_W-1:0]     word_t;
  typedef logic [`DC_WORD_W/8-1:0]   strb_t;
  typedef logic [`DC_ADDR_W-1:0]     addr_t;
  typedef logic [`DC_TAG_W-1:0]      tag_t;
  typedef logic [`DC_INDEX_W-1:0]    index_t;
  typedef logic [`DC_OFFSET_W-1:0]   offset_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

  // Ages run 0 (newest) to ways-1 (oldest)
  typedef logic [$clog2(`DC_WAYS)-1:0] age_t;

  // Per-line state, 24 bits
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } meta_t;

  typedef enum logic [1:0] {
    idle,
    lookup,
    writeback,
    refill
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module cache_array #(
  parameter type entry_t = logic
) (
  input  logic               clk,
  input  logic               rst,
  input  dcache_pkg::index_t rd_index,
  output entry_t             rd_entry,
  input  logic               wr_en,
  input  dcache_pkg::index_t wr_index,
  input  entry_t             wr_entry
);

  entry_t entries [`DC_SETS];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `DC_SETS; i++)
        entries[i] <= '0;
    end
    else if (wr_en)
    begin
      entries[wr_index] <= wr_entry;
    end
  end

  assign rd_entry = entries[rd_index];  // Async read

endmodule

`default_nettype wire

//--- hdl/data_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module data_store (
  input  logic                clk,
  // CPU word port
  input  dcache_pkg::way_t    cpu_way,
  input  dcache_pkg::index_t  cpu_index,
  input  dcache_pkg::offset_t cpu_offset,
  input  logic                cpu_we,
  input  dcache_pkg::strb_t   cpu_strb,
  input  dcache_pkg::word_t   cpu_wdata,
  output dcache_pkg::word_t   cpu_rdata,
  // Burst word port
  input  dcache_pkg::way_t    line_way,
  input  dcache_pkg::index_t  line_index,
  input  dcache_pkg::offset_t line_offset,
  input  logic                line_we,
  input  dcache_pkg::word_t   line_wdata,
  output dcache_pkg::word_t   line_rdata
);

  import dcache_pkg::*;

  word_t lines [`DC_WAYS][`DC_SETS][`DC_LINE_WORDS];
  word_t cpu_word;
  word_t merged;

  assign cpu_word = lines[cpu_way][cpu_index][cpu_offset];

  // Byte merge of the store into the current word
  always_comb
  begin
    merged = cpu_word;
    for (int b = 0; b < `DC_WORD_W/8; b++)
    begin
      if (cpu_strb[b])
        merged[8*b +: 8] = cpu_wdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (cpu_we)
      lines[cpu_way][cpu_index][cpu_offset] <= merged;
    if (line_we)
      lines[line_way][line_index][line_offset] <= line_wdata;  // Refill word
  end

  // A store returns the merged word
  assign cpu_rdata  = cpu_we ? merged : cpu_word;
  assign line_rdata = lines[line_way][line_index][line_offset];

endmodule

`default_nettype wire

//--- hdl/lru_policy.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module lru_policy (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::index_t   index,
  input  logic [`DC_WAYS-1:0]  valid,
  input  logic                 touch,
  input  dcache_pkg::way_t     touch_way,
  output dcache_pkg::way_t     victim
);

  import dcache_pkg::*;

  age_t age     [`DC_WAYS];
  age_t age_nxt [`DC_WAYS];
  age_t oldest;
  logic found_invalid;

  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_age
    cache_array #(
      .entry_t (age_t)
    ) age_array (
      .clk      (clk),
      .rst      (rst),
      .rd_index (index),
      .rd_entry (age[w]),
      .wr_en    (touch),
      .wr_index (index),
      .wr_entry (age_nxt[w])
    );
  end

  //////////////////////////////
  // Age update
  //////////////////////////////

  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (way_t'(w) == touch_way)
        age_nxt[w] = '0;
      else if (age[w] <= age[touch_way])
        age_nxt[w] = age[w] + 1'b1;
      else
        age_nxt[w] = age[w];
    end
  end

  //////////////////////////////
  // Victim choice
  //////////////////////////////

  always_comb
  begin
    victim        = '0;
    oldest        = age[0];
    found_invalid = 1'b0;
    // Lowest free way first
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (!valid[w] && !found_invalid)
      begin
        victim        = way_t'(w);
        found_invalid = 1'b1;
      end
    end
    if (!found_invalid)
    begin
      for (int w = 1; w < `DC_WAYS; w++)
      begin
        if (age[w] > oldest)  // Strict, so ties keep the lower way
        begin
          victim = way_t'(w);
          oldest = age[w];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/line_fill.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module line_fill (
  input  logic                clk,
  input  logic                rst,
  input  logic                start_wb,
  input  logic                start_fill,
  input  dcache_pkg::addr_t   line_addr,
  output logic                done,
  // Toward the data store
  output dcache_pkg::offset_t line_offset,
  output logic                line_we,
  output dcache_pkg::word_t   line_wdata,
  input  dcache_pkg::word_t   line_rdata,
  // Memory read
  output logic                mem_rd_req,
  output dcache_pkg::addr_t   mem_rd_addr,
  input  logic                mem_rd_valid,
  input  dcache_pkg::word_t   mem_rd_data,
  // Memory write
  output logic                mem_wr_req,
  output dcache_pkg::addr_t   mem_wr_addr,
  output dcache_pkg::word_t   mem_wr_data,
  input  logic                mem_wr_ready
);

  import dcache_pkg::*;

  logic    busy;
  logic    wb_dir;  // 1 writeback, 0 refill
  offset_t count;
  addr_t   base;
  logic    xfer;
  logic    last;

  // One word moves per accepted or valid cycle
  assign xfer = busy && (wb_dir ? mem_wr_ready : mem_rd_valid);
  assign last = (count == offset_t'(`DC_LINE_WORDS - 1));

  //////////////////////////////
  // Burst control
  //////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy   <= 1'b0;
      wb_dir <= 1'b0;
      count  <= '0;
      done   <= 1'b0;
    end
    else
    begin
      done <= xfer && last;
      if (start_wb || start_fill)
      begin
        busy   <= 1'b1;
        wb_dir <= start_wb;
        count  <= '0;
      end
      else if (xfer)
      begin
        count <= count + 1'b1;
        if (last)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_wb || start_fill)
      base <= line_addr;
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign mem_rd_req  = busy && !wb_dir;
  assign mem_rd_addr = base;
  assign mem_wr_req  = busy && wb_dir;
  assign mem_wr_addr = base;
  assign mem_wr_data = line_rdata;  // Word at the current count

  assign line_offset = count;
  assign line_we     = mem_rd_req && mem_rd_valid;
  assign line_wdata  = mem_rd_data;

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  // CPU request
  input  logic                                req,
  input  logic                                we,
  input  dcache_pkg::addr_t                   addr,
  input  dcache_pkg::word_t                   wdata,
  input  dcache_pkg::strb_t                   wstrb,
  output logic                                ok,
  // Meta arrays
  input  dcache_pkg::meta_t [`DC_WAYS-1:0]    meta_rd,
  output logic [`DC_WAYS-1:0]                 meta_we,
  output dcache_pkg::meta_t                   meta_wr,
  output dcache_pkg::index_t                  index,
  // Data store and LRU
  output dcache_pkg::way_t                    hit_way,
  input  dcache_pkg::way_t                    victim,
  output logic                                touch,
  output logic                                cpu_we,
  // Burst engine
  output logic                                start_wb,
  output logic                                start_fill,
  output dcache_pkg::addr_t                   line_addr,
  output dcache_pkg::way_t                    fill_way,
  input  logic                                done
);

  import dcache_pkg::*;

  localparam int LOW_W = `DC_OFFSET_W + 2;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  addr_t       addr_q;
  logic        we_q;
  way_t        victim_q;
  tag_t        tag_q;
  addr_t       req_base;
  meta_t       victim_meta;
  logic        hit;

  assign tag_q       = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign index       = addr_q[LOW_W +: `DC_INDEX_W];
  assign req_base    = {tag_q, index, {LOW_W{1'b0}}};
  assign victim_meta = meta_rd[victim];
  assign fill_way    = victim_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= idle;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk)
  begin
    if (state == idle && req)
    begin
      addr_q <= addr;
      we_q   <= we;
    end
    if (state == lookup && !hit)
      victim_q <= victim;  // Fixed for the whole miss
  end

  //////////////////////////////
  // Tag compare
  //////////////////////////////

  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (meta_rd[w].valid && meta_rd[w].tag == tag_q)
      begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb
  begin
    state_nxt  = state;
    ok         = 1'b0;
    touch      = 1'b0;
    cpu_we     = 1'b0;
    meta_we    = '0;
    meta_wr    = meta_rd[hit_way];
    start_wb   = 1'b0;
    start_fill = 1'b0;
    line_addr  = req_base;
    case (state)
      idle:
        if (req)
          state_nxt = lookup;
      lookup:
        if (hit)
        begin
          ok        = 1'b1;
          touch     = 1'b1;
          cpu_we    = we_q && (wstrb != '0);
          state_nxt = idle;
          if (we_q)
          begin
            meta_we[hit_way] = 1'b1;
            meta_wr.dirty    = 1'b1;
          end
        end
        else if (victim_meta.valid && victim_meta.dirty)
        begin
          start_wb  = 1'b1;
          line_addr = {victim_meta.tag, index, {LOW_W{1'b0}}};  // Victim line base
          state_nxt = writeback;
        end
        else
        begin
          start_fill = 1'b1;
          state_nxt  = refill;
        end
      writeback:
        if (done)
        begin
          start_fill = 1'b1;
          state_nxt  = refill;
        end
      refill:
        if (done)
        begin
          // New line is valid and clean, then replay
          meta_we[victim_q] = 1'b1;
          meta_wr.valid     = 1'b1;
          meta_wr.dirty     = 1'b0;
          meta_wr.tag       = tag_q;
          state_nxt         = lookup;
        end
      default:
        state_nxt = idle;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_top (
  input  logic              clk,
  input  logic              rst,
  // CPU
  input  logic              req,
  input  logic              we,
  input  dcache_pkg::addr_t addr,
  input  dcache_pkg::word_t wdata,
  input  dcache_pkg::strb_t wstrb,
  output dcache_pkg::word_t rdata,
  output logic              ok,
  // Memory read
  output logic              mem_rd_req,
  output dcache_pkg::addr_t mem_rd_addr,
  input  logic              mem_rd_valid,
  input  dcache_pkg::word_t mem_rd_data,
  // Memory write
  output logic              mem_wr_req,
  output dcache_pkg::addr_t mem_wr_addr,
  output dcache_pkg::word_t mem_wr_data,
  input  logic              mem_wr_ready
);

  import dcache_pkg::*;

  meta_t [`DC_WAYS-1:0] meta_rd;
  logic  [`DC_WAYS-1:0] meta_we;
  logic  [`DC_WAYS-1:0] way_valid;
  meta_t                meta_wr;
  index_t               index;
  way_t                 hit_way;
  way_t                 victim;
  way_t                 fill_way;
  logic                 touch;
  logic                 cpu_we;
  logic                 start_wb;
  logic                 start_fill;
  addr_t                line_addr;
  logic                 done;
  offset_t              line_offset;
  logic                 line_we;
  word_t                line_wdata;
  word_t                line_rdata;

  dcache_ctrl ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .ok         (ok),
    .meta_rd    (meta_rd),
    .meta_we    (meta_we),
    .meta_wr    (meta_wr),
    .index      (index),
    .hit_way    (hit_way),
    .victim     (victim),
    .touch      (touch),
    .cpu_we     (cpu_we),
    .start_wb   (start_wb),
    .start_fill (start_fill),
    .line_addr  (line_addr),
    .fill_way   (fill_way),
    .done       (done)
  );

  // One meta array per way
  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_meta
    cache_array #(
      .entry_t (meta_t)
    ) meta_array (
      .clk      (clk),
      .rst      (rst),
      .rd_index (index),
      .rd_entry (meta_rd[w]),
      .wr_en    (meta_we[w]),
      .wr_index (index),
      .wr_entry (meta_wr)
    );
    assign way_valid[w] = meta_rd[w].valid;
  end

  data_store data_inst (
    .clk         (clk),
    .cpu_way     (hit_way),
    .cpu_index   (index),
    .cpu_offset  (addr[2 +: `DC_OFFSET_W]),  // Request held until ok
    .cpu_we      (cpu_we),
    .cpu_strb    (wstrb),
    .cpu_wdata   (wdata),
    .cpu_rdata   (rdata),
    .line_way    (fill_way),
    .line_index  (index),
    .line_offset (line_offset),
    .line_we     (line_we),
    .line_wdata  (line_wdata),
    .line_rdata  (line_rdata)
  );

  lru_policy lru_inst (
    .clk       (clk),
    .rst       (rst),
    .index     (index),
    .valid     (way_valid),
    .touch     (touch),
    .touch_way (hit_way),
    .victim    (victim)
  );

  line_fill fill_inst (
    .clk          (clk),
    .rst          (rst),
    .start_wb     (start_wb),
    .start_fill   (start_fill),
    .line_addr    (line_addr),
    .done         (done),
    .line_offset  (line_offset),
    .line_we      (line_we),
    .line_wdata   (line_wdata),
    .line_rdata   (line_rdata),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .mem_wr_req   (mem_wr_req),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_ready (mem_wr_ready)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/dcache_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_assert (
  input logic clk,
  input logic rst,
  input logic ok,
  input logic mem_rd_req,
  input logic mem_wr_req
);

  // Response lasts a single cycle
  ok_single: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok was high for two consecutive cycles");

  // One burst direction at a time
  burst_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_req && mem_wr_req))
    else $error("mem_rd_req and mem_wr_req high together");

  ok_quiet_in_burst: assert property (@(posedge clk) disable iff (rst)
    (mem_rd_req || mem_wr_req) |-> !ok)
    else $error("ok raised while a burst request was active");

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_tb;

  import dcache_pkg::*;

  localparam int PERIOD      = 4;
  localparam int RAND_OPS    = 400;
  localparam int FLUSH_TAGS  = 8;
  localparam int NUM_REQ     = 10 + RAND_OPS + `DC_SETS * FLUSH_TAGS;
  localparam longint TIMEOUT = (longint'(NUM_REQ) * 40 + 2000) * PERIOD;

  logic  clk, rst;
  logic  req, we, ok;
  addr_t addr;
  word_t wdata, rdata;
  strb_t wstrb;
  logic  mem_rd_req, mem_rd_valid, mem_wr_req, mem_wr_ready;
  addr_t mem_rd_addr, mem_wr_addr;
  word_t mem_rd_data, mem_wr_data;

  // Memory images, sparse
  word_t mem_dut [addr_t];
  word_t ref_mem [addr_t];

  // Reference cache state
  logic  m_valid [`DC_SETS][`DC_WAYS];
  logic  m_dirty [`DC_SETS][`DC_WAYS];
  tag_t  m_tag   [`DC_SETS][`DC_WAYS];
  age_t  m_age   [`DC_SETS][`DC_WAYS];
  word_t m_data  [`DC_WAYS][`DC_SETS][`DC_LINE_WORDS];

  word_t exp_q[$];        // Expected rdata per ok
  addr_t exp_wb_addr[$];
  word_t exp_wb_data[$];

  string test_name = "reset";
  int    seed = 32'h8638;
  int    rd_bursts = 0;
  int    wb_bursts = 0;
  addr_t last_rd_addr;
  logic  burst_seen;

  tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(3)) clk_gen_inst (.clk(clk), .rst(rst));

  dcache_top dcache_top_inst (
    .clk(clk), .rst(rst),
    .req(req), .we(we), .addr(addr), .wdata(wdata), .wstrb(wstrb),
    .rdata(rdata), .ok(ok),
    .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr),
    .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data),
    .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data), .mem_wr_ready(mem_wr_ready)
  );

  bind dcache_top dcache_assert dcache_assert_inst (
    .clk(clk), .rst(rst), .ok(ok), .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req)
  );

  task automatic report_mismatch(input string what, input word_t expv, input word_t actv);
    $display("FAIL %s expected %h actual %h", what, expv, actv);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Error in %s: %s", test_name, why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  function automatic word_t fill_pattern(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t dut_word(input addr_t a);
    return mem_dut.exists(a) ? mem_dut[a] : fill_pattern(a);
  endfunction

  function automatic word_t ref_word(input addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_pattern(a);
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t model_access(input logic st, input addr_t a,
                                         input word_t wd, input strb_t ws);
    tag_t   t;
    index_t s;
    int     o;
    int     hw;
    int     v;
    age_t   old;
    addr_t  base;
    word_t  w;
    t  = a[31:10];
    s  = a[9:6];
    o  = a[5:2];
    hw = -1;
    for (int i = 0; i < `DC_WAYS; i++)
      if (m_valid[s][i] && m_tag[s][i] == t)
        hw = i;
    if (hw < 0)
    begin
      v = -1;
      for (int i = `DC_WAYS - 1; i >= 0; i--)  // Lowest invalid way
        if (!m_valid[s][i])
          v = i;
      if (v < 0)
      begin
        v = 0;
        for (int i = 1; i < `DC_WAYS; i++)
          if (m_age[s][i] > m_age[s][v])
            v = i;
      end
      if (m_valid[s][v] && m_dirty[s][v])
      begin
        base = {m_tag[s][v], s, 6'b0};
        exp_wb_addr.push_back(base);
        for (int k = 0; k < `DC_LINE_WORDS; k++)
        begin
          exp_wb_data.push_back(m_data[v][s][k]);
          ref_mem[base + 4 * k] = m_data[v][s][k];
        end
      end
      base = {t, s, 6'b0};
      for (int k = 0; k < `DC_LINE_WORDS; k++)
        m_data[v][s][k] = ref_word(base + 4 * k);
      m_valid[s][v] = 1'b1;
      m_dirty[s][v] = 1'b0;
      m_tag[s][v]   = t;
      hw = v;
    end
    w = m_data[hw][s][o];
    if (st)
    begin
      for (int b = 0; b < 4; b++)
        if (ws[b])
          w[8*b +: 8] = wd[8*b +: 8];
      m_data[hw][s][o] = w;
      m_dirty[s][hw]   = 1'b1;
    end
    old = m_age[s][hw];
    for (int i = 0; i < `DC_WAYS; i++)
    begin
      if (i == hw)
        m_age[s][i] = '0;
      else if (m_age[s][i] <= old)
        m_age[s][i] = m_age[s][i] + 1'b1;
    end
    return w;
  endfunction

  task automatic run_access(input logic st, input addr_t a, input word_t wd,
                            input strb_t ws, output int cycles);
    exp_q.push_back(model_access(st, a, wd, ws));
    @(posedge clk);
    req   <= 1'b1;
    we    <= st;
    addr  <= a;
    wdata <= wd;
    wstrb <= ws;
    cycles = 0;
    burst_seen = 1'b0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (mem_rd_req || mem_wr_req)
        burst_seen = 1'b1;
    end while (!ok);
    req <= 1'b0;
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  initial
  begin
    int rd_cnt;
    int wr_cnt;
    rd_cnt = 0;
    wr_cnt = 0;
    mem_rd_valid = 1'b0;
    mem_rd_data  = '0;
    mem_wr_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      if (mem_rd_req && mem_rd_valid)
      begin
        rd_cnt++;
        if (rd_cnt == `DC_LINE_WORDS)
        begin
          rd_bursts++;
          last_rd_addr = mem_rd_addr;
        end
      end
      if (mem_rd_req && rd_cnt < `DC_LINE_WORDS)
      begin
        mem_rd_valid <= ($random(seed) & 3) != 0;  // Random gaps
        mem_rd_data  <= dut_word(mem_rd_addr + 4 * rd_cnt);
      end
      else
        mem_rd_valid <= 1'b0;
      if (!mem_rd_req)
        rd_cnt = 0;

      if (mem_wr_req && mem_wr_ready)
      begin
        if (wr_cnt == 0)
        begin
          assert (exp_wb_addr.size() > 0) else abort_run("unexpected writeback");
          assert (mem_wr_addr == exp_wb_addr[0])
            else report_mismatch({test_name, " wb addr"}, exp_wb_addr[0], mem_wr_addr);
          void'(exp_wb_addr.pop_front());
        end
        assert (exp_wb_data.size() > 0) else abort_run("extra writeback word");
        assert (mem_wr_data == exp_wb_data[0])
          else report_mismatch({test_name, " wb data"}, exp_wb_data[0], mem_wr_data);
        void'(exp_wb_data.pop_front());
        mem_dut[mem_wr_addr + 4 * wr_cnt] = mem_wr_data;
        wr_cnt++;
        if (wr_cnt == `DC_LINE_WORDS)
          wb_bursts++;
      end
      if (mem_wr_req && wr_cnt < `DC_LINE_WORDS)
        mem_wr_ready <= ($random(seed) & 3) != 0;
      else
        mem_wr_ready <= 1'b0;
      if (!mem_wr_req)
        wr_cnt = 0;
    end
  end

  // Response checker
  initial
  begin
    word_t expv;
    forever
    begin
      @(posedge clk);
      if (!rst && ok)
      begin
        assert (exp_q.size() > 0) else abort_run("ok without an outstanding request");
        expv = exp_q.pop_front();
        assert (rdata === expv) else report_mismatch(test_name, expv, rdata);
      end
    end
  end

  initial
  begin
    #(TIMEOUT);
    $display("Watchdog expired in %s, the DUT stopped responding", test_name);
    $display("Result: FAILED");
    $fatal(1);
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    int    cyc;
    int    rd_before;
    int    wb_before;
    addr_t a;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    @(negedge rst);

    test_name = "miss_read";
    a = 32'h0000_1240;
    rd_before = rd_bursts;
    run_access(1'b0, a, '0, '0, cyc);
    assert (rd_bursts == rd_before + 1) else abort_run("miss did not do one refill");
    assert (last_rd_addr == (a & ~32'h3f))
      else report_mismatch(test_name, a & ~32'h3f, last_rd_addr);

    test_name = "byte_store";
    run_access(1'b1, a + 4, 32'hdead_beef, 4'b0101, cyc);
    run_access(1'b0, a + 4, '0, '0, cyc);

    test_name = "hit_load";
    run_access(1'b0, a + 8, '0, '0, cyc);
    assert (cyc == 2) else report_mismatch({test_name, " latency"}, 2, cyc);
    assert (!burst_seen) else abort_run("a hit issued a memory request");

    test_name = "evict_dirty";
    for (int t = 1; t <= 4; t++)
      run_access(1'b1, {22'(t), 4'd5, 6'h10}, 32'h1111_0000 * t, 4'hf, cyc);
    wb_before = wb_bursts;
    run_access(1'b0, {22'd5, 4'd5, 6'h0}, '0, '0, cyc);
    assert (wb_bursts == wb_before + 1) else abort_run("expected exactly one writeback");

    test_name = "random_mix";
    for (int i = 0; i < RAND_OPS; i++)
    begin
      a = {22'($unsigned($random(seed)) % 6), 4'($unsigned($random(seed)) % 3),
           4'($random(seed)), 2'b00};
      run_access(1'($random(seed)), a, word_t'($random(seed)), strb_t'($random(seed)), cyc);
    end

    test_name = "flush";
    for (int s = 0; s < `DC_SETS; s++)
      for (int t = 0; t < FLUSH_TAGS; t++)
        run_access(1'b0, {22'(32'h100 + t), 4'(s), 6'h0}, '0, '0, cyc);
    repeat (4) @(posedge clk);
    for (int s = 0; s < `DC_SETS; s++)
      for (int w = 0; w < `DC_WAYS; w++)
        assert (!(m_valid[s][w] && m_dirty[s][w])) else abort_run("dirty line left after flush");
    assert (exp_q.size() == 0 && exp_wb_addr.size() == 0 && exp_wb_data.size() == 0)
      else abort_run("responses or writebacks still outstanding");
    foreach (ref_mem[k])
      assert (dut_word(k) == ref_mem[k]) else report_mismatch(test_name, ref_mem[k], dut_word(k));
    foreach (mem_dut[k])
      assert (mem_dut[k] == ref_word(k)) else report_mismatch(test_name, ref_word(k), mem_dut[k]);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+include
hdl/dcache_pkg.sv
hdl/cache_array.sv
hdl/data_store.sv
hdl/lru_policy.sv
hdl/line_fill.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/tb_clk_gen.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := dcache_tb
FLIST := dcache.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
